// File: hw/zx_cfg.svh
// Bus core constants for the 128K host board
// Widths, port decodes, divider and speed-change settings
`ifndef ZX_CFG_SVH
`define ZX_CFG_SVH

// ====================
// Widths
`define ZX_ADDR_W       16
`define ZX_DATA_W       8
`define ZX_PHYS_W       18
`define ZX_OFFS_W       14
`define ZX_ROM_BIT      17

// ====================
// Speed control
`define ZX_SPEEDS       5
`define ZX_DIV_W        5
`define ZX_SETTLE_TICKS 3

// ====================
// Port decodes, 7FFD needs A15 and A1 low, ULA any even port
`define ZX_PAGE_MASK    16'h8002
`define ZX_PAGE_MATCH   16'h0000
`define ZX_ULA_MASK     16'h0001
`define ZX_ULA_MATCH    16'h0000
`define ZX_IO_RD_DATA   8'hFF

// Fixed banks in windows 1 and 2
`define ZX_WIN1_BANK    3'd5
`define ZX_WIN2_BANK    3'd2

`endif

// File: hw/zx_pkg.sv
// Shared types of the bus core
// Vector widths, bus cycle, memory command, ULA state and sequencer states
`include "zx_cfg.svh"

package zx_pkg;

	typedef logic [`ZX_ADDR_W-1:0] cpu_addr_t;
	typedef logic [`ZX_DATA_W-1:0] byte_t;
	// Bit 17 selects ROM, then bank and offset
	typedef logic [`ZX_PHYS_W-1:0] phys_addr_t;
	// Code 0 is the slowest, 32 clocks per pulse
	typedef logic [2:0] speed_t;
	typedef logic [2:0] bank_t;

	typedef enum logic [1:0] {
		CYC_MEM_RD,
		CYC_MEM_WR,
		CYC_IO_RD,
		CYC_IO_WR
	} cycle_kind_t;

	// Request from the CPU side
	typedef struct packed {
		cycle_kind_t kind;
		cpu_addr_t   addr;
		byte_t       data;
	} bus_cycle_t;

	// Command to external memory
	typedef struct packed {
		phys_addr_t addr;
		logic       rd;
		logic       we;
		byte_t      din;
	} mem_cmd_t;

	typedef struct packed {
		logic [2:0] border;
		logic       ear;
		logic       mic;
	} ula_state_t;

	typedef enum logic [2:0] {
		S_IDLE,
		S_EXEC,
		S_MEMWAIT,
		S_ACK,
		S_SETTLE
	} seq_state_t;

endpackage

// File: hw/zx_ce_divider.sv
// CPU clock-enable divider
// Free-running counter, pulse period of 32 clocks shifted right by the speed code
`timescale 1ns/100ps
`include "zx_cfg.svh"

module zx_ce_divider (
	input  logic            clk_sys,
	input  logic            reset,
	input  zx_pkg::speed_t  speed,
	output logic            ce
);

	logic [`ZX_DIV_W-1:0] cnt;
	logic [`ZX_DIV_W-1:0] mask;
	zx_pkg::speed_t       speed_eff;

	// Codes past the last one run at the fastest speed
	always_comb begin
		if (speed >= zx_pkg::speed_t'(`ZX_SPEEDS))
			speed_eff = zx_pkg::speed_t'(`ZX_SPEEDS - 1);
		else
			speed_eff = speed;
	end

	assign mask = {`ZX_DIV_W{1'b1}} >> speed_eff;

	always_ff @(posedge clk_sys) begin
		if (reset)
			cnt <= '0;
		else
			cnt <= cnt + 1'b1;
	end

	// One pulse each time the masked low bits wrap
	assign ce = ((cnt & mask) == '0);

endmodule

// File: hw/zx_bus_fsm.sv
// Bus sequencer
// Four-phase handshake, memory wait and speed-change settle
`timescale 1ns/100ps
`include "zx_cfg.svh"

module zx_bus_fsm (
	input  logic               clk_sys,
	input  logic               reset,
	input  logic               bus_req,
	input  zx_pkg::bus_cycle_t bus_cycle,
	input  zx_pkg::speed_t     speed_sel,
	input  logic               ce,
	input  logic               ram_ready,
	input  zx_pkg::byte_t      ram_rdata,
	output zx_pkg::speed_t     active_speed,
	output logic               cpu_run,
	output logic               exec,
	output logic               mem_phase,
	output logic               bus_ack,
	output zx_pkg::byte_t      bus_rdata
);

	zx_pkg::seq_state_t state;
	logic [1:0]         settle_cnt;
	logic               is_mem;
	logic               settle_done;

	assign is_mem = (bus_cycle.kind == zx_pkg::CYC_MEM_RD) ||
		(bus_cycle.kind == zx_pkg::CYC_MEM_WR);

	assign settle_done = (settle_cnt == 2'(`ZX_SETTLE_TICKS));

	// ====================
	// State outputs
	assign exec      = (state == zx_pkg::S_EXEC);
	assign mem_phase = (exec && is_mem) || (state == zx_pkg::S_MEMWAIT);
	assign bus_ack   = (state == zx_pkg::S_ACK);

	// ====================
	// Sequencer
	always_ff @(posedge clk_sys) begin
		if (reset) begin
			state        <= zx_pkg::S_IDLE;
			settle_cnt   <= '0;
			active_speed <= '0;
			cpu_run      <= 1'b1;
		end else begin
			case (state)
				zx_pkg::S_IDLE: begin
					if (bus_req && cpu_run && ce) begin
						state <= zx_pkg::S_EXEC;
					end else if (!bus_req && (speed_sel != active_speed)) begin
						// Hold the CPU while the divider moves
						active_speed <= speed_sel;
						cpu_run      <= 1'b0;
						settle_cnt   <= '0;
						state        <= zx_pkg::S_SETTLE;
					end
				end
				zx_pkg::S_EXEC: begin
					if (!is_mem)
						state <= zx_pkg::S_ACK;
					else if (ram_ready)
						state <= zx_pkg::S_ACK;
					else
						state <= zx_pkg::S_MEMWAIT;
				end
				zx_pkg::S_MEMWAIT: begin
					if (ram_ready)
						state <= zx_pkg::S_ACK;
				end
				zx_pkg::S_ACK: begin
					// Ack held until the requester lets go
					if (!bus_req)
						state <= zx_pkg::S_IDLE;
				end
				zx_pkg::S_SETTLE: begin
					if (settle_done && ram_ready) begin
						cpu_run <= 1'b1;
						state   <= zx_pkg::S_IDLE;
					end else if (ce && !settle_done) begin
						settle_cnt <= settle_cnt + 1'b1;
					end
				end
				default: begin
					state <= zx_pkg::S_IDLE;
				end
			endcase
		end
	end

	// Read data, memory at ready, open bus on I/O reads
	always_ff @(posedge clk_sys) begin
		if (exec && (bus_cycle.kind == zx_pkg::CYC_IO_RD))
			bus_rdata <= `ZX_IO_RD_DATA;
		else if (mem_phase && ram_ready)
			bus_rdata <= ram_rdata;
	end

endmodule

// File: hw/zx_mem_map.sv
// 128K paging register at 7FFD
// Maps CPU addresses to physical memory commands, no writes to ROM
`timescale 1ns/100ps
`include "zx_cfg.svh"

module zx_mem_map (
	input  logic               clk_sys,
	input  logic               reset,
	input  zx_pkg::bus_cycle_t bus_cycle,
	input  logic               exec,
	input  logic               mem_phase,
	output zx_pkg::mem_cmd_t   mem_cmd
);

	zx_pkg::bank_t      page_bank;
	logic               page_rom;
	logic               page_lock;
	logic               page_write;
	logic               win_rom;
	zx_pkg::bank_t      win_bank;
	zx_pkg::phys_addr_t phys;

	// ====================
	// Paging register
	assign page_write = exec && (bus_cycle.kind == zx_pkg::CYC_IO_WR) &&
		((bus_cycle.addr & `ZX_PAGE_MASK) == `ZX_PAGE_MATCH) && !page_lock;

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			page_bank <= '0;
			page_rom  <= 1'b0;
			page_lock <= 1'b0;
		end else if (page_write) begin
			page_bank <= bus_cycle.data[2:0];
			page_rom  <= bus_cycle.data[4];
			// Lock stays until reset
			page_lock <= bus_cycle.data[5];
		end
	end

	// ====================
	// Window decode
	always_comb begin
		win_rom  = 1'b0;
		win_bank = page_bank;
		case (bus_cycle.addr[15:14])
			2'd0: begin
				win_rom  = 1'b1;
				win_bank = {2'b00, page_rom};
			end
			2'd1: win_bank = `ZX_WIN1_BANK;
			2'd2: win_bank = `ZX_WIN2_BANK;
			default: win_bank = page_bank;
		endcase
	end

	assign phys = {win_rom, win_bank, bus_cycle.addr[`ZX_OFFS_W-1:0]};

	assign mem_cmd.addr = phys;
	assign mem_cmd.rd   = mem_phase && (bus_cycle.kind == zx_pkg::CYC_MEM_RD);
	assign mem_cmd.we   = mem_phase && (bus_cycle.kind == zx_pkg::CYC_MEM_WR) &&
		!phys[`ZX_ROM_BIT];
	assign mem_cmd.din  = bus_cycle.data;

endmodule

// File: hw/zx_ula_port.sv
// ULA output port
// Border colour, EAR and MIC latched on writes to even ports
`timescale 1ns/100ps
`include "zx_cfg.svh"

module zx_ula_port (
	input  logic               clk_sys,
	input  logic               reset,
	input  zx_pkg::bus_cycle_t bus_cycle,
	input  logic               exec,
	output zx_pkg::ula_state_t ula
);

	logic ula_write;

	assign ula_write = exec && (bus_cycle.kind == zx_pkg::CYC_IO_WR) &&
		((bus_cycle.addr & `ZX_ULA_MASK) == `ZX_ULA_MATCH);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			ula <= '0;
		end else if (ula_write) begin
			ula.border <= bus_cycle.data[2:0];
			// EAR on bit 4, MIC on bit 3
			ula.ear    <= bus_cycle.data[4];
			ula.mic    <= bus_cycle.data[3];
		end
	end

endmodule

// File: hw/zx_bus_core.sv
// Bus core top level
// Divider, sequencer, memory map and ULA port
`timescale 1ns/100ps

module zx_bus_core (
	input  logic               clk_sys,
	input  logic               reset,
	input  logic               bus_req,
	input  zx_pkg::bus_cycle_t bus_cycle,
	output logic               bus_ack,
	output zx_pkg::byte_t      bus_rdata,
	input  zx_pkg::speed_t     speed_sel,
	output logic               cpu_ce,
	output logic               cpu_run,
	output zx_pkg::mem_cmd_t   mem_cmd,
	input  logic               ram_ready,
	input  zx_pkg::byte_t      ram_rdata,
	output zx_pkg::ula_state_t ula
);

	zx_pkg::speed_t active_speed;
	logic           exec;
	logic           mem_phase;

	zx_ce_divider u_ce_divider (
		.clk_sys (clk_sys),
		.reset   (reset),
		.speed   (active_speed),
		.ce      (cpu_ce)
	);

	zx_bus_fsm u_bus_fsm (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.bus_req      (bus_req),
		.bus_cycle    (bus_cycle),
		.speed_sel    (speed_sel),
		.ce           (cpu_ce),
		.ram_ready    (ram_ready),
		.ram_rdata    (ram_rdata),
		.active_speed (active_speed),
		.cpu_run      (cpu_run),
		.exec         (exec),
		.mem_phase    (mem_phase),
		.bus_ack      (bus_ack),
		.bus_rdata    (bus_rdata)
	);

	zx_mem_map u_mem_map (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.bus_cycle (bus_cycle),
		.exec      (exec),
		.mem_phase (mem_phase),
		.mem_cmd   (mem_cmd)
	);

	zx_ula_port u_ula_port (
		.clk_sys   (clk_sys),
		.reset     (reset),
		.bus_cycle (bus_cycle),
		.exec      (exec),
		.ula       (ula)
	);

endmodule

// File: bench/zx_bus_core_props.sv
// Bus core assertions, bound to the top level
// Handshake order and memory command sanity
`timescale 1ns/100ps
`include "zx_cfg.svh"

module zx_bus_core_props (
	input logic             clk_sys,
	input logic             reset,
	input logic             bus_req,
	input logic             bus_ack,
	input zx_pkg::mem_cmd_t mem_cmd
);

	// Ack only answers a live request
	ack_rise: assert property (@(posedge clk_sys) disable iff (reset)
		$rose(bus_ack) |-> bus_req)
		else $error("bus_ack rose without bus_req");

	// Ack released only once the request is gone
	ack_fall: assert property (@(posedge clk_sys) disable iff (reset)
		$fell(bus_ack) |-> !$past(bus_req))
		else $error("bus_ack fell while bus_req was still high");

	rom_we: assert property (@(posedge clk_sys) disable iff (reset)
		!(mem_cmd.we && mem_cmd.addr[`ZX_ROM_BIT]))
		else $error("write strobe on a ROM address");

	rd_we: assert property (@(posedge clk_sys) disable iff (reset)
		!(mem_cmd.rd && mem_cmd.we))
		else $error("read and write strobes high together");

endmodule

bind zx_bus_core zx_bus_core_props u_props (
	.clk_sys (clk_sys),
	.reset   (reset),
	.bus_req (bus_req),
	.bus_ack (bus_ack),
	.mem_cmd (mem_cmd)
);

// File: bench/zx_bus_core_tb.sv
// Testbench for the bus core
// Clock, reset, LFSR stimulus, RAM model, compare tasks and directed tests
`timescale 1ns/100ps
`include "zx_cfg.svh"

module zx_bus_core_tb;

	// Covers the slowest speed and the longest RAM wait on every cycle
	localparam int MAX_CYCLES = 20000;

	logic               clk_sys = 1'b0;
	logic               reset;
	logic               bus_req;
	zx_pkg::bus_cycle_t req_cycle;
	logic               bus_ack;
	zx_pkg::byte_t      bus_rdata;
	zx_pkg::speed_t     speed_sel;
	logic               cpu_ce;
	logic               cpu_run;
	zx_pkg::mem_cmd_t   mem_cmd;
	logic               ram_ready;
	zx_pkg::byte_t      ram_rdata;
	zx_pkg::ula_state_t ula;

	logic [31:0] lfsr = 32'hf554;
	int          cycles = 0;
	int          errors = 0;
	int          test_errors = 0;
	int          tests_run = 0;
	int          tests_failed = 0;
	string       cur_test;

	zx_bus_core dut (.*, .bus_cycle(req_cycle));

	always #20 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= MAX_CYCLES) begin
			$display("Timeout after %0d cycles, the DUT stopped answering", cycles);
			$display("Some tests failed");
			$finish;
		end
	end

	// ====================
	// Stimulus helpers
	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		logic [31:0] n;
		n = s >> 1;
		if (s[0])
			n = n ^ 32'hA3000000;
		return n;
	endfunction

	// One LFSR step per bit taken
	function automatic logic [31:0] rand_bits(input int count);
		logic [31:0] r;
		int          i;
		r = '0;
		for (i = 0; i < count; i++) begin
			lfsr = lfsr_next(lfsr);
			r = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	// RAM contents are the low address byte mixed with the bank
	function automatic zx_pkg::byte_t ram_data(input zx_pkg::phys_addr_t a);
		return a[7:0] ^ {a[16:14], 5'b00000};
	endfunction

	// Expected physical address from the 128K window rules
	function automatic zx_pkg::phys_addr_t map_addr(input zx_pkg::cpu_addr_t a,
		input zx_pkg::bank_t bank, input logic rom);
		case (a[15:14])
			2'd0: return {1'b1, 2'b00, rom, a[13:0]};
			2'd1: return {1'b0, 3'd5, a[13:0]};
			2'd2: return {1'b0, 3'd2, a[13:0]};
			default: return {1'b0, bank, a[13:0]};
		endcase
	endfunction

	task automatic next_cycle();
		@(posedge clk_sys);
		#2;
	endtask

	// ====================
	// Compare tasks
	task automatic check_byte(input string what, input zx_pkg::byte_t exp,
		input zx_pkg::byte_t act);
		if (exp !== act) begin
			$display("Error %s %s: expected %h, actual %h", cur_test, what, exp, act);
			test_errors++;
		end
	endtask

	task automatic check_phys(input string what, input zx_pkg::phys_addr_t exp,
		input zx_pkg::phys_addr_t act);
		if (exp !== act) begin
			$display("Error %s %s: expected %h, actual %h", cur_test, what, exp, act);
			test_errors++;
		end
	endtask

	task automatic check_ula(input string what, input zx_pkg::ula_state_t exp,
		input zx_pkg::ula_state_t act);
		if (exp !== act) begin
			$display("Error %s %s: expected %b, actual %b", cur_test, what, exp, act);
			test_errors++;
		end
	endtask

	task automatic check_bit(input string what, input logic exp, input logic act);
		if (exp !== act) begin
			$display("Error %s %s: expected %b, actual %b", cur_test, what, exp, act);
			test_errors++;
		end
	endtask

	task automatic start_test(input string name);
		cur_test = name;
		test_errors = 0;
	endtask

	task automatic end_test();
		tests_run++;
		if (test_errors == 0) begin
			$display("%s: ok", cur_test);
		end else begin
			$display("%s: %0d errors", cur_test, test_errors);
			tests_failed++;
			errors += test_errors;
		end
	endtask

	// ====================
	// One four-phase transaction where RAM answers delay cycles after the command
	task automatic bus_cycle(input zx_pkg::cycle_kind_t kind, input zx_pkg::cpu_addr_t addr,
		input zx_pkg::byte_t data, input int delay, output zx_pkg::phys_addr_t phys,
		output zx_pkg::byte_t din, output logic we_seen);
		logic started;
		logic ready_given;
		int   cnt;
		started = 1'b0;
		we_seen = 1'b0;
		phys = '0;
		din = '0;
		cnt = delay;
		ready_given = (delay == 0);
		req_cycle.kind = kind;
		req_cycle.addr = addr;
		req_cycle.data = data;
		ram_ready = ready_given;
		bus_req = 1'b1;
		while (!bus_ack) begin
			next_cycle();
			if (bus_ack && !ready_given) begin
				$display("%s: bus_ack rose while ram_ready was still low", cur_test);
				test_errors++;
			end
			if ((mem_cmd.rd || mem_cmd.we) && !started) begin
				started = 1'b1;
				phys = mem_cmd.addr;
				din = mem_cmd.din;
			end else if (started && cnt > 0) begin
				cnt--;
			end
			we_seen |= mem_cmd.we;
			if (started && cnt == 0)
				ready_given = 1'b1;
			ram_ready = ready_given;
			ram_rdata = ram_data(mem_cmd.addr);
		end
		next_cycle();
		check_bit("ack held", 1'b1, bus_ack);
		bus_req = 1'b0;
		ram_ready = 1'b1;
		while (bus_ack)
			next_cycle();
	endtask

	// ====================
	// Directed tests
	task automatic ula_port_io();
		zx_pkg::byte_t      d;
		zx_pkg::ula_state_t exp;
		zx_pkg::phys_addr_t p;
		zx_pkg::byte_t      din;
		logic               we;
		start_test("ula_port");
		d = zx_pkg::byte_t'(rand_bits(8));
		bus_cycle(zx_pkg::CYC_IO_WR, 16'h00FE, d, 0, p, din, we);
		exp.border = d[2:0];
		exp.ear = d[4];
		exp.mic = d[3];
		check_ula("ula state", exp, ula);
		// I/O reads see an open bus
		bus_cycle(zx_pkg::CYC_IO_RD, 16'h00FE, 8'h00, 0, p, din, we);
		check_byte("io read data", 8'hFF, bus_rdata);
		end_test();
	endtask

	task automatic paging_map_reads();
		zx_pkg::bank_t      bank;
		logic [31:0]        r;
		logic               rom;
		int                 w;
		zx_pkg::cpu_addr_t  a;
		zx_pkg::phys_addr_t exp;
		zx_pkg::phys_addr_t p;
		zx_pkg::byte_t      din;
		logic               we;
		start_test("paging_map");
		bank = zx_pkg::bank_t'(rand_bits(3));
		r = rand_bits(1);
		rom = r[0];
		bus_cycle(zx_pkg::CYC_IO_WR, 16'h7FFD, {3'b000, rom, 1'b0, bank}, 0, p, din, we);
		for (w = 0; w < 4; w++) begin
			a = zx_pkg::cpu_addr_t'(rand_bits(14));
			a[15:14] = w[1:0];
			bus_cycle(zx_pkg::CYC_MEM_RD, a, 8'h00, int'(rand_bits(2)), p, din, we);
			exp = map_addr(a, bank, rom);
			check_phys("window addr", exp, p);
			check_byte("read data", ram_data(exp), bus_rdata);
		end
		end_test();
	endtask

	task automatic paging_lock_hold();
		zx_pkg::phys_addr_t p;
		zx_pkg::byte_t      din;
		logic               we;
		start_test("paging_lock");
		// Bank 6 with the lock bit and then a try for bank 1
		bus_cycle(zx_pkg::CYC_IO_WR, 16'h7FFD, 8'h26, 0, p, din, we);
		bus_cycle(zx_pkg::CYC_IO_WR, 16'h7FFD, 8'h01, 0, p, din, we);
		bus_cycle(zx_pkg::CYC_MEM_RD, 16'hC123, 8'h00, 1, p, din, we);
		check_phys("window 3 addr", map_addr(16'hC123, 3'd6, 1'b0), p);
		end_test();
	endtask

	task automatic rom_write_protect();
		zx_pkg::byte_t      d;
		zx_pkg::phys_addr_t p;
		zx_pkg::byte_t      din;
		logic               we;
		start_test("rom_protect");
		bus_cycle(zx_pkg::CYC_MEM_WR, 16'h1234, 8'h5A, 0, p, din, we);
		check_bit("rom write strobe", 1'b0, we);
		d = zx_pkg::byte_t'(rand_bits(8));
		bus_cycle(zx_pkg::CYC_MEM_WR, 16'h8456, d, int'(rand_bits(2)), p, din, we);
		check_bit("ram write strobe", 1'b1, we);
		check_phys("ram addr", map_addr(16'h8456, 3'd6, 1'b0), p);
		check_byte("ram din", d, din);
		end_test();
	endtask

	task automatic speed_change_periods();
		int             i;
		int             n;
		int             gap;
		zx_pkg::speed_t code;
		start_test("speed_change");
		// Codes 1 to 4 and then back to 0
		for (i = 0; i < `ZX_SPEEDS; i++) begin
			code = zx_pkg::speed_t'((i + 1) % `ZX_SPEEDS);
			speed_sel = code;
			n = 0;
			while (cpu_run && n < 8) begin
				next_cycle();
				n++;
			end
			check_bit("cpu_run dropped", 1'b0, cpu_run);
			while (!cpu_run)
				next_cycle();
			while (!cpu_ce)
				next_cycle();
			gap = 0;
			do begin
				next_cycle();
				gap++;
			end while (!cpu_ce);
			check_byte("ce period", zx_pkg::byte_t'(32 >> code), zx_pkg::byte_t'(gap));
		end
		end_test();
	endtask

	task automatic backpressure_read();
		zx_pkg::phys_addr_t exp;
		zx_pkg::phys_addr_t p;
		zx_pkg::byte_t      din;
		logic               we;
		start_test("backpressure");
		exp = map_addr(16'h4321, 3'd6, 1'b0);
		bus_cycle(zx_pkg::CYC_MEM_RD, 16'h4321, 8'h00, 12, p, din, we);
		check_phys("addr", exp, p);
		check_byte("read data", ram_data(exp), bus_rdata);
		end_test();
	endtask

	initial begin
		reset = 1'b1;
		bus_req = 1'b0;
		req_cycle = '0;
		speed_sel = '0;
		ram_ready = 1'b1;
		ram_rdata = '0;
		repeat (10) @(posedge clk_sys);
		#2;
		reset = 1'b0;
		next_cycle();
		ula_port_io();
		paging_map_reads();
		paging_lock_hold();
		rom_write_protect();
		speed_change_periods();
		backpressure_read();
		$display("Tests run %0d, failed %0d, errors %0d", tests_run, tests_failed, errors);
		if (errors == 0)
			$display("All tests passed");
		else
			$display("Some tests failed");
		$finish;
	end

endmodule

// File: sim.f
+incdir+hw
hw/zx_pkg.sv
hw/zx_ce_divider.sv
hw/zx_bus_fsm.sv
hw/zx_mem_map.sv
hw/zx_ula_port.sv
hw/zx_bus_core.sv
bench/zx_bus_core_props.sv
bench/zx_bus_core_tb.sv

// File: Makefile
# Verilator build of the bus core testbench
.PHONY: help test clean

help:
	@echo "make test   build and run the testbench"
	@echo "make clean  remove the build output"

test:
	verilator --binary --timing --assert -f sim.f --top-module zx_bus_core_tb -Mdir obj_dir
	@out="$$(./obj_dir/Vzx_bus_core_tb)"; echo "$$out"; \
		echo "$$out" | grep -q "All tests passed"

clean:
	rm -rf obj_dir
